/* source/mmu_cfg.svh */
// Sv32 MMU configuration
// Address widths and TLB sizes shared by the package and the top level

`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// Sv32 virtual address width
`define VALEN 32

// Sv32 physical address width, 22-bit PPN plus 12-bit offset
`define PALEN 34

// Fully associative TLB sizes
`define ITLB_ENTRIES 8
`define DTLB_ENTRIES 8

`endif

/* source/mmu_pkg.sv */
// Sv32 MMU types
// Address and PTE types, per-interface structs and the walker state encoding

`include "mmu_cfg.svh"

package mmu_pkg;

    typedef logic [`VALEN-1:0] vaddr_t;
    typedef logic [`PALEN-1:0] paddr_t;
    typedef logic [19:0]       vpn_t;
    typedef logic [21:0]       ppn_t;

    // Sv32 page table entry, MSB first
    typedef struct packed {
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    // Fetch unit side
    typedef struct packed {
        logic   i_req;
        vaddr_t i_vaddr;
    } if2mmu_s;

    typedef struct packed {
        paddr_t i_paddr;
        logic   i_hit;
        logic   i_page_fault;
    } mmu2if_s;

    // Load/store unit side, also carries the CSR state
    typedef struct packed {
        logic   d_req;
        vaddr_t d_vaddr;
        logic   st_req;
        logic   is_amo;
        logic   en_vaddr;
        logic   en_ld_st_vaddr;
        ppn_t   satp_ppn;
        logic   mxr;
        logic   tlb_flush;
        logic   lsu_flush;
    } lsu2mmu_s;

    typedef struct packed {
        paddr_t d_paddr;
        logic   d_hit;
        logic   ld_page_fault;
        logic   st_page_fault;
    } mmu2lsu_s;

    // Data cache port used by the walker
    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } dcache2mmu_s;

    typedef struct packed {
        logic   req;
        paddr_t paddr;
    } mmu2dcache_s;

    // TLB lookup and refill
    typedef struct packed {
        logic tlb_req;
        vpn_t vpage_addr;
        logic tlb_flush;
    } mmu2tlb_s;

    typedef struct packed {
        logic hit;
        pte_t pte;
        logic page_4M;
    } tlb2mmu_s;

    typedef struct packed {
        vpn_t vpn;
        pte_t pte;
        logic page_4M;
    } ptw2tlb_s;

    // Walker control, requests arrive already gated by the enables
    typedef struct packed {
        ppn_t   satp_ppn;
        logic   mxr;
        logic   flush_req;
        logic   itlb_req;
        vaddr_t itlb_vaddr;
        logic   itlb_hit;
        logic   dtlb_req;
        vaddr_t dtlb_vaddr;
        logic   dtlb_hit;
        logic   is_store;
    } mmu2ptw_s;

    typedef struct packed {
        logic pte_error;
        logic iwalk_active;
    } ptw2mmu_s;

    typedef enum logic [2:0] {
        IDLE,
        L1_REQ,
        L0_REQ,
        REFILL,
        FAULT
    } ptw_state_e;

endpackage

/* source/tlb.sv */
// Fully associative TLB
// Combinational lookup with superpage match, round-robin refill, full flush

`timescale 1ns/1ps

module tlb #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic               clk,
    input  logic               rst_i,
    input  mmu_pkg::mmu2tlb_s  mmu2tlb_i,
    input  mmu_pkg::ptw2tlb_s  ptw2tlb_i,
    input  logic               tlb_update_i,
    output mmu_pkg::tlb2mmu_s  tlb2mmu_o
);

    localparam int IDX_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

    // Entry storage
    mmu_pkg::vpn_t          tag_q [NUM_ENTRIES];
    mmu_pkg::pte_t          pte_q [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] sp_q;
    logic [NUM_ENTRIES-1:0] valid_q;
    logic [IDX_W-1:0]       repl_ptr_q;

    logic [NUM_ENTRIES-1:0] match;

    // Tag compare, superpages ignore VPN[0]
    always_comb begin
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (sp_q[i]) begin
                match[i] = valid_q[i] & (tag_q[i][19:10] == mmu2tlb_i.vpage_addr[19:10]);
            end else begin
                match[i] = valid_q[i] & (tag_q[i] == mmu2tlb_i.vpage_addr);
            end
        end
    end

    // Pick the lowest matching entry
    always_comb begin
        tlb2mmu_o.hit     = mmu2tlb_i.tlb_req & (|match);
        tlb2mmu_o.pte     = '0;
        tlb2mmu_o.page_4M = 1'b0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                tlb2mmu_o.pte     = pte_q[i];
                tlb2mmu_o.page_4M = sp_q[i];
            end
        end
    end

    // Valid bits and replacement pointer
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q    <= '0;
            repl_ptr_q <= '0;
        end else if (mmu2tlb_i.tlb_flush) begin
            valid_q <= '0;
        end else if (tlb_update_i) begin
            valid_q[repl_ptr_q] <= 1'b1;
            // Wrap for non power-of-two sizes too
            if (repl_ptr_q == IDX_W'(NUM_ENTRIES - 1)) begin
                repl_ptr_q <= '0;
            end else begin
                repl_ptr_q <= repl_ptr_q + 1'b1;
            end
        end
    end

    // Entry payload written at the replacement slot
    always_ff @(posedge clk) begin
        if (tlb_update_i) begin
            tag_q[repl_ptr_q] <= ptw2tlb_i.vpn;
            pte_q[repl_ptr_q] <= ptw2tlb_i.pte;
            sp_q[repl_ptr_q]  <= ptw2tlb_i.page_4M;
        end
    end

endmodule

/* source/ptw.sv */
// Sv32 page table walker
// Two-level walk over the data cache port, leaf and permission checks,
// then a refill of the TLB that missed or a one-cycle fault

`timescale 1ns/1ps

module ptw (
    input  logic                  clk,
    input  logic                  rst_i,
    input  mmu_pkg::mmu2ptw_s     mmu2ptw_i,
    output mmu_pkg::ptw2mmu_s     ptw2mmu_o,
    output mmu_pkg::ptw2tlb_s     ptw2tlb_o,
    output logic                  itlb_update_o,
    output logic                  dtlb_update_o,
    input  mmu_pkg::dcache2mmu_s  dcache2ptw_i,
    output mmu_pkg::mmu2dcache_s  ptw2dcache_o
);

    mmu_pkg::ptw_state_e state_q, state_d;

    // Walk context
    mmu_pkg::vaddr_t vaddr_q;
    mmu_pkg::ppn_t   ppn_q;
    mmu_pkg::pte_t   pte_q;
    logic            page_4M_q;
    logic            iwalk_q;
    logic            store_q;
    logic            flush_pend_q;

    mmu_pkg::pte_t rd_pte;
    logic          itlb_miss;
    logic          dtlb_miss;
    logic          in_req;
    logic          abort;
    logic          rd_bad;
    logic          rd_leaf;
    logic          rd_perm_ok;

    assign rd_pte    = dcache2ptw_i.rdata;
    assign itlb_miss = mmu2ptw_i.itlb_req & ~mmu2ptw_i.itlb_hit;
    assign dtlb_miss = mmu2ptw_i.dtlb_req & ~mmu2ptw_i.dtlb_hit;
    assign in_req    = (state_q == mmu_pkg::L1_REQ) | (state_q == mmu_pkg::L0_REQ);
    assign abort     = mmu2ptw_i.flush_req | flush_pend_q;

    // Invalid entry or reserved W without R
    assign rd_bad  = ~rd_pte.v | (rd_pte.w & ~rd_pte.r);
    assign rd_leaf = rd_pte.r | rd_pte.x;

    // Access kind permission, then A and D
    always_comb begin
        if (iwalk_q) begin
            rd_perm_ok = rd_pte.x;
        end else if (store_q) begin
            rd_perm_ok = rd_pte.w;
        end else begin
            rd_perm_ok = rd_pte.r | (mmu2ptw_i.mxr & rd_pte.x);
        end
        rd_perm_ok = rd_perm_ok & rd_pte.a & (~store_q | rd_pte.d);
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            mmu_pkg::IDLE: begin
                if ((itlb_miss | dtlb_miss) & ~mmu2ptw_i.flush_req) begin
                    state_d = mmu_pkg::L1_REQ;
                end
            end
            mmu_pkg::L1_REQ: begin
                if (dcache2ptw_i.ack) begin
                    if (abort) begin
                        state_d = mmu_pkg::IDLE;
                    end else if (rd_bad) begin
                        state_d = mmu_pkg::FAULT;
                    end else if (rd_leaf) begin
                        // Superpage leaf needs PPN[0] clear
                        if ((rd_pte.ppn[9:0] != '0) | ~rd_perm_ok) begin
                            state_d = mmu_pkg::FAULT;
                        end else begin
                            state_d = mmu_pkg::REFILL;
                        end
                    end else begin
                        state_d = mmu_pkg::L0_REQ;
                    end
                end
            end
            mmu_pkg::L0_REQ: begin
                if (dcache2ptw_i.ack) begin
                    if (abort) begin
                        state_d = mmu_pkg::IDLE;
                    end else if (rd_bad | ~rd_leaf | ~rd_perm_ok) begin
                        // No leaf at level 0 is a fault as well
                        state_d = mmu_pkg::FAULT;
                    end else begin
                        state_d = mmu_pkg::REFILL;
                    end
                end
            end
            default: state_d = mmu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q      <= mmu_pkg::IDLE;
            flush_pend_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Remember a flush until the outstanding ack returns
            if (state_d == mmu_pkg::IDLE) begin
                flush_pend_q <= 1'b0;
            end else if (in_req & mmu2ptw_i.flush_req) begin
                flush_pend_q <= 1'b1;
            end
        end
    end

    // Latch the miss on entry, the PTE on every ack
    always_ff @(posedge clk) begin
        if ((state_q == mmu_pkg::IDLE) & (state_d == mmu_pkg::L1_REQ)) begin
            // ITLB miss has priority
            iwalk_q <= itlb_miss;
            vaddr_q <= itlb_miss ? mmu2ptw_i.itlb_vaddr : mmu2ptw_i.dtlb_vaddr;
            store_q <= ~itlb_miss & mmu2ptw_i.is_store;
            ppn_q   <= mmu2ptw_i.satp_ppn;
        end else if (in_req & dcache2ptw_i.ack) begin
            pte_q     <= rd_pte;
            ppn_q     <= rd_pte.ppn;
            page_4M_q <= (state_q == mmu_pkg::L1_REQ);
        end
    end

    // PTE address is ppn * 4096 + vpn slice * 4
    assign ptw2dcache_o.req   = in_req;
    assign ptw2dcache_o.paddr = (state_q == mmu_pkg::L1_REQ) ?
                                {ppn_q, vaddr_q[31:22], 2'b00} :
                                {ppn_q, vaddr_q[21:12], 2'b00};

    assign ptw2tlb_o.vpn     = vaddr_q[31:12];
    assign ptw2tlb_o.pte     = pte_q;
    assign ptw2tlb_o.page_4M = page_4M_q;

    assign itlb_update_o = (state_q == mmu_pkg::REFILL) & iwalk_q;
    assign dtlb_update_o = (state_q == mmu_pkg::REFILL) & ~iwalk_q;

    assign ptw2mmu_o.pte_error    = (state_q == mmu_pkg::FAULT);
    assign ptw2mmu_o.iwalk_active = iwalk_q;

endmodule

/* source/mmu.sv */
// Sv32 MMU top level
// ITLB and DTLB lookups, shared page table walker, physical address
// forming and page fault routing for fetch, load and store

`timescale 1ns/1ps

`include "mmu_cfg.svh"

module mmu (
    input  logic                  clk,
    input  logic                  rst_i,
    input  mmu_pkg::lsu2mmu_s     lsu2mmu_i,
    output mmu_pkg::mmu2lsu_s     mmu2lsu_o,
    input  mmu_pkg::if2mmu_s      if2mmu_i,
    output mmu_pkg::mmu2if_s      mmu2if_o,
    input  mmu_pkg::dcache2mmu_s  dcache2mmu_i,
    output mmu_pkg::mmu2dcache_s  mmu2dcache_o
);

    mmu_pkg::mmu2tlb_s mmu2itlb;
    mmu_pkg::mmu2tlb_s mmu2dtlb;
    mmu_pkg::tlb2mmu_s itlb2mmu;
    mmu_pkg::tlb2mmu_s dtlb2mmu;
    mmu_pkg::ptw2tlb_s ptw2tlb;
    mmu_pkg::mmu2ptw_s mmu2ptw;
    mmu_pkg::ptw2mmu_s ptw2mmu;
    logic              itlb_update;
    logic              dtlb_update;

    // Instruction side lookup
    assign mmu2itlb.tlb_req    = if2mmu_i.i_req;
    assign mmu2itlb.vpage_addr = if2mmu_i.i_vaddr[`VALEN-1:12];
    assign mmu2itlb.tlb_flush  = lsu2mmu_i.tlb_flush;

    tlb #(
        .NUM_ENTRIES (`ITLB_ENTRIES)
    ) itlb_module (
        .clk          (clk),
        .rst_i        (rst_i),
        .mmu2tlb_i    (mmu2itlb),
        .ptw2tlb_i    (ptw2tlb),
        .tlb_update_i (itlb_update),
        .tlb2mmu_o    (itlb2mmu)
    );

    // Data side lookup
    assign mmu2dtlb.tlb_req    = lsu2mmu_i.d_req;
    assign mmu2dtlb.vpage_addr = lsu2mmu_i.d_vaddr[`VALEN-1:12];
    assign mmu2dtlb.tlb_flush  = lsu2mmu_i.tlb_flush;

    tlb #(
        .NUM_ENTRIES (`DTLB_ENTRIES)
    ) dtlb_module (
        .clk          (clk),
        .rst_i        (rst_i),
        .mmu2tlb_i    (mmu2dtlb),
        .ptw2tlb_i    (ptw2tlb),
        .tlb_update_i (dtlb_update),
        .tlb2mmu_o    (dtlb2mmu)
    );

    // Walker inputs, requests only count when translation is on
    assign mmu2ptw.satp_ppn   = lsu2mmu_i.satp_ppn;
    assign mmu2ptw.mxr        = lsu2mmu_i.mxr;
    assign mmu2ptw.flush_req  = lsu2mmu_i.lsu_flush;
    assign mmu2ptw.itlb_req   = if2mmu_i.i_req & lsu2mmu_i.en_vaddr;
    assign mmu2ptw.itlb_vaddr = if2mmu_i.i_vaddr;
    assign mmu2ptw.itlb_hit   = itlb2mmu.hit;
    assign mmu2ptw.dtlb_req   = lsu2mmu_i.d_req & lsu2mmu_i.en_ld_st_vaddr;
    assign mmu2ptw.dtlb_vaddr = lsu2mmu_i.d_vaddr;
    assign mmu2ptw.dtlb_hit   = dtlb2mmu.hit;
    // AMO needs write permission like a store
    assign mmu2ptw.is_store   = lsu2mmu_i.st_req | lsu2mmu_i.is_amo;

    ptw ptw_module (
        .clk           (clk),
        .rst_i         (rst_i),
        .mmu2ptw_i     (mmu2ptw),
        .ptw2mmu_o     (ptw2mmu),
        .ptw2tlb_o     (ptw2tlb),
        .itlb_update_o (itlb_update),
        .dtlb_update_o (dtlb_update),
        .dcache2ptw_i  (dcache2mmu_i),
        .ptw2dcache_o  (mmu2dcache_o)
    );

    // Fetch response
    always_comb begin
        // Bare mode passes the address through
        mmu2if_o.i_paddr = {{(`PALEN-`VALEN){1'b0}}, if2mmu_i.i_vaddr};
        mmu2if_o.i_hit   = if2mmu_i.i_req;
        if (lsu2mmu_i.en_vaddr) begin
            mmu2if_o.i_paddr = {itlb2mmu.pte.ppn, if2mmu_i.i_vaddr[11:0]};
            mmu2if_o.i_hit   = itlb2mmu.hit;
            // 4 MiB page keeps a 22-bit offset
            if (itlb2mmu.page_4M) begin
                mmu2if_o.i_paddr[21:12] = if2mmu_i.i_vaddr[21:12];
            end
        end
        mmu2if_o.i_page_fault = ptw2mmu.pte_error & ptw2mmu.iwalk_active;
    end

    // Load/store response
    always_comb begin
        mmu2lsu_o.d_paddr = {{(`PALEN-`VALEN){1'b0}}, lsu2mmu_i.d_vaddr};
        mmu2lsu_o.d_hit   = lsu2mmu_i.d_req;
        if (lsu2mmu_i.en_ld_st_vaddr) begin
            mmu2lsu_o.d_paddr = {dtlb2mmu.pte.ppn, lsu2mmu_i.d_vaddr[11:0]};
            mmu2lsu_o.d_hit   = dtlb2mmu.hit;
            if (dtlb2mmu.page_4M) begin
                mmu2lsu_o.d_paddr[21:12] = lsu2mmu_i.d_vaddr[21:12];
            end
        end
        // Data faults go by the kind of the held request
        mmu2lsu_o.st_page_fault = ptw2mmu.pte_error & ~ptw2mmu.iwalk_active &
                                  (lsu2mmu_i.st_req | lsu2mmu_i.is_amo);
        mmu2lsu_o.ld_page_fault = ptw2mmu.pte_error & ~ptw2mmu.iwalk_active &
                                  ~(lsu2mmu_i.st_req | lsu2mmu_i.is_amo) &
                                  lsu2mmu_i.d_req;
    end

endmodule

/* testbench/mmu_props.sv */
// MMU protocol properties
// Cache handshake, refill routing and response exclusivity checks bound into mmu

`timescale 1ns/1ps

module mmu_props (
    input logic                  clk,
    input logic                  rst_i,
    input mmu_pkg::if2mmu_s      if_req_i,
    input mmu_pkg::lsu2mmu_s     lsu_req_i,
    input mmu_pkg::mmu2dcache_s  cache_req_i,
    input mmu_pkg::dcache2mmu_s  cache_rsp_i,
    input logic                  itlb_update_i,
    input logic                  dtlb_update_i,
    input mmu_pkg::mmu2if_s      if_rsp_i,
    input mmu_pkg::mmu2lsu_s     lsu_rsp_i
);

    // Request and its address hold until the ack
    req_hold_a: assert property (@(posedge clk) disable iff (rst_i)
        cache_req_i.req && !cache_rsp_i.ack |=> cache_req_i.req && $stable(cache_req_i.paddr))
        else $error("cache request dropped or changed before its ack");

    // A walk refills one TLB only and only for a requester that still misses
    one_update_a: assert property (@(posedge clk) disable iff (rst_i)
        !(itlb_update_i && dtlb_update_i) &&
        (!itlb_update_i || (if_req_i.i_req && !if_rsp_i.i_hit)) &&
        (!dtlb_update_i || (lsu_req_i.d_req && !lsu_rsp_i.d_hit)))
        else $error("TLB update pulses overlap or refill a TLB with no waiting miss");

    // Walker comes out of reset idle
    reset_idle_a: assert property (@(posedge clk) rst_i |=> !cache_req_i.req)
        else $error("cache request high right after reset");

    // Hit and fault exclude each other per port
    hit_fault_a: assert property (@(posedge clk) disable iff (rst_i)
        !(if_rsp_i.i_hit && if_rsp_i.i_page_fault) &&
        !(lsu_rsp_i.d_hit && (lsu_rsp_i.ld_page_fault || lsu_rsp_i.st_page_fault)))
        else $error("hit and page fault on the same port");

endmodule

bind mmu mmu_props props (
    .clk           (clk),
    .rst_i         (rst_i),
    .if_req_i      (if2mmu_i),
    .lsu_req_i     (lsu2mmu_i),
    .cache_req_i   (mmu2dcache_o),
    .cache_rsp_i   (dcache2mmu_i),
    .itlb_update_i (itlb_update),
    .dtlb_update_i (dtlb_update),
    .if_rsp_i      (mmu2if_o),
    .lsu_rsp_i     (mmu2lsu_o)
);

/* testbench/mmu_tb.sv */
// Sv32 MMU testbench
// Page table memory model with random ack delay, reference walk and directed tests

`timescale 1ns/1ps

module mmu_tb;

    localparam int NUM_RANDOM  = 24;
    // Worst walk is two reads of up to 5 cycles plus refill, hit and request edges
    localparam int WALK_CYCLES = 16;
    localparam int NUM_WALKS   = 20 + 2 * NUM_RANDOM;
    localparam int CYCLE_LIMIT = NUM_WALKS * WALK_CYCLES + 300;
    localparam int K_FETCH = 0;
    localparam int K_LOAD  = 1;
    localparam int K_STORE = 2;
    // PTE flag bits D A G U X W R V
    localparam logic [7:0] PV = 8'h01;
    localparam logic [7:0] PR = 8'h02;
    localparam logic [7:0] PW = 8'h04;
    localparam logic [7:0] PX = 8'h08;
    localparam logic [7:0] PA = 8'h40;
    localparam logic [7:0] PD = 8'h80;
    localparam mmu_pkg::ppn_t ROOT_PPN = 22'h00100;
    localparam mmu_pkg::ppn_t T0_PPN   = 22'h00101;
    localparam mmu_pkg::ppn_t T1_PPN   = 22'h00102;

    logic                  clk;
    logic                  rst;
    mmu_pkg::if2mmu_s      if2mmu;
    mmu_pkg::mmu2if_s      mmu2if;
    mmu_pkg::lsu2mmu_s     lsu2mmu;
    mmu_pkg::mmu2lsu_s     mmu2lsu;
    mmu_pkg::dcache2mmu_s  dcache2mmu;
    mmu_pkg::mmu2dcache_s  mmu2dcache;

    logic [31:0]   pt_mem [mmu_pkg::paddr_t];
    logic [31:0]   lfsr = 32'hc7d3_ef66;
    logic [31:0]   mem_rnd;
    logic          mem_busy = 1'b0;
    int            ack_wait;
    int            cache_reqs = 0;
    int            cycle_count = 0;
    int            err_value = 0;
    int            err_other = 0;
    mmu_pkg::pte_t refill_pte;

    mmu DUT (
        .clk          (clk),
        .rst_i        (rst),
        .lsu2mmu_i    (lsu2mmu),
        .mmu2lsu_o    (mmu2lsu),
        .if2mmu_i     (if2mmu),
        .mmu2if_o     (mmu2if),
        .dcache2mmu_i (dcache2mmu),
        .mmu2dcache_o (mmu2dcache)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [31:0] read_pte(input mmu_pkg::paddr_t a);
        if (pt_mem.exists(a)) begin
            return pt_mem[a];
        end
        return 32'h0;
    endfunction

    function automatic mmu_pkg::pte_t make_pte(input mmu_pkg::ppn_t ppn, input logic [7:0] f);
        return {ppn, 2'b00, f};
    endfunction

    task automatic put_pte(input mmu_pkg::ppn_t tbl, input logic [9:0] idx,
                           input mmu_pkg::pte_t pte);
        pt_mem[{tbl, idx, 2'b00}] = pte;
    endtask

    // Cache model with 1 to 4 cycles from request to ack
    always @(posedge clk) begin
        #1;
        dcache2mmu.ack = 1'b0;
        if (!rst && mmu2dcache.req) begin
            if (!mem_busy) begin
                mem_busy   = 1'b1;
                cache_reqs = cache_reqs + 1;
                draw_bits(2, mem_rnd);
                ack_wait = int'(mem_rnd) + 1;
            end else begin
                ack_wait = ack_wait - 1;
                if (ack_wait == 0) begin
                    dcache2mmu.ack   = 1'b1;
                    dcache2mmu.rdata = read_pte(mmu2dcache.paddr);
                    mem_busy         = 1'b0;
                end
            end
        end
    end

    // Last PTE written into either TLB
    always @(negedge clk) begin
        if (DUT.itlb_update || DUT.dtlb_update) begin
            refill_pte = DUT.ptw2tlb.pte;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, a request got no response", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_paddr(input string name, input mmu_pkg::paddr_t got,
                               input mmu_pkg::paddr_t exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_pte(input string name, input mmu_pkg::pte_t got,
                             input mmu_pkg::pte_t exp);
        if (got !== exp) begin
            err_value++;
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            err_other++;
            $display("Wrong number of cache requests during %s: %0d seen, %0d expected",
                     what, got, exp);
        end
    endtask

    // Reference Sv32 walk over the table model
    task automatic ref_translate(input mmu_pkg::vaddr_t va, input int kind, input logic mxr,
                                 output mmu_pkg::paddr_t pa, output logic fault,
                                 output mmu_pkg::pte_t leaf);
        mmu_pkg::pte_t p;
        logic          is_super;
        logic          ok;
        fault    = 1'b0;
        is_super = 1'b0;
        p = read_pte({lsu2mmu.satp_ppn, va[31:22], 2'b00});
        if (!p.v || (p.w && !p.r)) begin
            fault = 1'b1;
        end else if (p.r || p.x) begin
            is_super = 1'b1;
            fault    = (p.ppn[9:0] != 10'h0);
        end else begin
            p = read_pte({p.ppn, va[21:12], 2'b00});
            fault = !p.v || (p.w && !p.r) || !(p.r || p.x);
        end
        case (kind)
            K_FETCH: ok = p.x;
            K_STORE: ok = p.w && p.d;
            default: ok = p.r || (mxr && p.x);
        endcase
        if (!ok || !p.a) begin
            fault = 1'b1;
        end
        leaf = p;
        pa   = is_super ? {p.ppn[21:10], va[21:0]} : {p.ppn, va[11:0]};
    endtask

    // Hold a fetch until hit or fault, then compare with the reference
    task automatic run_fetch(input mmu_pkg::vaddr_t va, output mmu_pkg::paddr_t pa);
        mmu_pkg::paddr_t epa;
        mmu_pkg::pte_t   leaf;
        logic            efault;
        logic            hit;
        logic            fault;
        ref_translate(va, K_FETCH, lsu2mmu.mxr, epa, efault, leaf);
        @(posedge clk);
        #1;
        if2mmu.i_req   = 1'b1;
        if2mmu.i_vaddr = va;
        @(negedge clk);
        while (!(mmu2if.i_hit || mmu2if.i_page_fault)) @(negedge clk);
        hit   = mmu2if.i_hit;
        fault = mmu2if.i_page_fault;
        pa    = mmu2if.i_paddr;
        @(posedge clk);
        #1;
        if2mmu.i_req = 1'b0;
        check_flag("i_hit", hit, !efault);
        check_flag("i_page_fault", fault, efault);
        if (!efault) begin
            check_paddr("i_paddr", pa, epa);
        end
    endtask

    task automatic run_data(input mmu_pkg::vaddr_t va, input logic st, input logic amo,
                            output mmu_pkg::paddr_t pa);
        mmu_pkg::paddr_t epa;
        mmu_pkg::pte_t   leaf;
        logic            efault;
        logic            hit;
        logic            ldf;
        logic            stf;
        ref_translate(va, (st || amo) ? K_STORE : K_LOAD, lsu2mmu.mxr, epa, efault, leaf);
        @(posedge clk);
        #1;
        lsu2mmu.d_req   = 1'b1;
        lsu2mmu.d_vaddr = va;
        lsu2mmu.st_req  = st;
        lsu2mmu.is_amo  = amo;
        @(negedge clk);
        while (!(mmu2lsu.d_hit || mmu2lsu.ld_page_fault || mmu2lsu.st_page_fault)) begin
            @(negedge clk);
        end
        hit = mmu2lsu.d_hit;
        ldf = mmu2lsu.ld_page_fault;
        stf = mmu2lsu.st_page_fault;
        pa  = mmu2lsu.d_paddr;
        @(posedge clk);
        #1;
        lsu2mmu.d_req  = 1'b0;
        lsu2mmu.st_req = 1'b0;
        lsu2mmu.is_amo = 1'b0;
        check_flag("d_hit", hit, !efault);
        check_flag("ld_page_fault", ldf, efault && !(st || amo));
        check_flag("st_page_fault", stf, efault && (st || amo));
        if (!efault) begin
            check_paddr("d_paddr", pa, epa);
        end
    endtask

    task automatic flush_tlbs();
        @(posedge clk);
        #1;
        lsu2mmu.tlb_flush = 1'b1;
        @(posedge clk);
        #1;
        lsu2mmu.tlb_flush = 1'b0;
    endtask

    task automatic build_tables();
        put_pte(ROOT_PPN, 10'd1, make_pte(T0_PPN, PV));
        put_pte(ROOT_PPN, 10'd2, make_pte(22'h00C00, PV | PR | PW | PX | PA | PD));
        // Superpage with PPN[0] not zero
        put_pte(ROOT_PPN, 10'd3, make_pte(22'h00C05, PV | PR | PX | PA));
        put_pte(ROOT_PPN, 10'd4, make_pte(T1_PPN, PV));
        put_pte(T0_PPN, 10'd0, make_pte(22'h02000, PV | PR | PW | PA | PD));
        put_pte(T0_PPN, 10'd1, make_pte(22'h02001, PV | PR | PA | PD));
        put_pte(T0_PPN, 10'd4, make_pte(22'h02004, PV | PX | PA));
        // Pointer at level 0 that is never a leaf
        put_pte(T0_PPN, 10'd5, make_pte(T1_PPN, PV));
        put_pte(T0_PPN, 10'd6, make_pte(22'h02006, PV | PR | PW | PD));
        for (int i = 0; i < 16; i++) begin
            put_pte(T1_PPN, 10'(i), make_pte(22'h03000 + 22'(i), PV | PR | PW | PX | PA | PD));
        end
    endtask

    task automatic test_bare();
        int start;
        start = cache_reqs;
        @(posedge clk);
        #1;
        if2mmu  = '{i_req: 1'b1, i_vaddr: 32'hDEAD_BEEC};
        lsu2mmu.d_req   = 1'b1;
        lsu2mmu.d_vaddr = 32'h1234_5678;
        @(negedge clk);
        check_paddr("i_paddr", mmu2if.i_paddr, {2'b00, 32'hDEAD_BEEC});
        check_flag("i_hit", mmu2if.i_hit, 1'b1);
        check_paddr("d_paddr", mmu2lsu.d_paddr, {2'b00, 32'h1234_5678});
        check_flag("d_hit", mmu2lsu.d_hit, 1'b1);
        @(posedge clk);
        #1;
        if2mmu.i_req  = 1'b0;
        lsu2mmu.d_req = 1'b0;
        @(negedge clk);
        check_flag("i_hit", mmu2if.i_hit, 1'b0);
        check_flag("d_hit", mmu2lsu.d_hit, 1'b0);
        repeat (4) @(posedge clk);
        check_count("bare mode", cache_reqs - start, 0);
    endtask

    task automatic test_load_walk();
        mmu_pkg::paddr_t pa;
        mmu_pkg::paddr_t epa;
        mmu_pkg::pte_t   leaf;
        logic            efault;
        int              start;
        flush_tlbs();
        start = cache_reqs;
        run_data(32'h0040_0123, 1'b0, 1'b0, pa);
        check_count("4 KiB load walk", cache_reqs - start, 2);
        ref_translate(32'h0040_0123, K_LOAD, 1'b0, epa, efault, leaf);
        check_pte("refilled pte", refill_pte, leaf);
        start = cache_reqs;
        run_data(32'h0040_0ABC, 1'b0, 1'b0, pa);
        check_count("repeated load", cache_reqs - start, 0);
        flush_tlbs();
        run_data(32'h0040_0008, 1'b1, 1'b0, pa);
        flush_tlbs();
        run_data(32'h0040_0010, 1'b0, 1'b1, pa);
    endtask

    task automatic test_superpage();
        mmu_pkg::paddr_t pa;
        int              start;
        flush_tlbs();
        start = cache_reqs;
        run_fetch(32'h0093_4567, pa);
        check_count("superpage fetch", cache_reqs - start, 1);
        check_paddr("i_paddr[21:0]", {12'h0, pa[21:0]}, {12'h0, 22'h13_4567});
        start = cache_reqs;
        run_fetch(32'h00BF_FFF0, pa);
        check_count("second superpage fetch", cache_reqs - start, 0);
    endtask

    task automatic test_faults();
        mmu_pkg::paddr_t pa;
        flush_tlbs();
        run_data(32'h0040_2000, 1'b0, 1'b0, pa);
        run_data(32'h0040_1000, 1'b1, 1'b0, pa);
        run_fetch(32'h0040_0000, pa);
        run_data(32'h00C0_0044, 1'b0, 1'b0, pa);
        run_fetch(32'h00C0_0100, pa);
        run_data(32'h0040_6000, 1'b0, 1'b0, pa);
        run_data(32'h0040_5000, 1'b0, 1'b0, pa);
        // Execute-only page is readable only through mxr
        run_data(32'h0040_4000, 1'b0, 1'b0, pa);
        lsu2mmu.mxr = 1'b1;
        run_data(32'h0040_4020, 1'b0, 1'b0, pa);
        lsu2mmu.mxr = 1'b0;
    endtask

    task automatic test_flush();
        mmu_pkg::paddr_t pa;
        mmu_pkg::paddr_t epa;
        mmu_pkg::pte_t   leaf;
        logic            efault;
        int              start;
        ref_translate(32'h0040_0010, K_LOAD, 1'b0, epa, efault, leaf);
        run_data(32'h0040_0010, 1'b0, 1'b0, pa);
        start = cache_reqs;
        run_data(32'h0040_0010, 1'b0, 1'b0, pa);
        check_count("load before flush", cache_reqs - start, 0);
        flush_tlbs();
        start = cache_reqs;
        run_data(32'h0040_0010, 1'b0, 1'b0, pa);
        check_count("load after flush", cache_reqs - start, 2);
        check_paddr("d_paddr after flush", pa, epa);
    endtask

    // Fetch and data requests issued together on fully permitted pages
    task automatic test_random();
        mmu_pkg::vaddr_t fva;
        mmu_pkg::vaddr_t dva;
        mmu_pkg::paddr_t fpa;
        mmu_pkg::paddr_t dpa;
        logic [31:0]     sel;
        logic [31:0]     off;
        logic [31:0]     st;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            @(negedge clk);
            draw_bits(1, sel);
            draw_bits(22, off);
            fva = sel[0] ? {10'h002, off[21:0]} : {10'h004, 6'h00, off[15:0]};
            draw_bits(1, sel);
            draw_bits(22, off);
            dva = sel[0] ? {10'h002, off[21:0]} : {10'h004, 6'h00, off[15:0]};
            draw_bits(1, st);
            fork
                run_fetch(fva, fpa);
                run_data(dva, st[0], 1'b0, dpa);
            join
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        if2mmu     = '0;
        lsu2mmu    = '0;
        dcache2mmu = '0;
        build_tables();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        test_bare();
        lsu2mmu.satp_ppn       = ROOT_PPN;
        lsu2mmu.en_vaddr       = 1'b1;
        lsu2mmu.en_ld_st_vaddr = 1'b1;
        test_load_walk();
        test_superpage();
        test_faults();
        test_flush();
        test_random();
        $display("Errors: %0d wrong values, %0d other", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* mmu.f */
+incdir+source
source/mmu_pkg.sv
source/tlb.sv
source/ptw.sv
source/mmu.sv
testbench/mmu_props.sv
testbench/mmu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the MMU testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f mmu.f --top-module mmu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmmu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    exit 0
fi
exit 1
